// File: verilog/soc_bus_pkg.sv
package soc_bus_pkg;

   // ********************************************************************
   // Wishbone bus widths.
   // ********************************************************************

   localparam int BUS_W = 32; // Data and address width.
   localparam int SEL_W = BUS_W / 8; // One select bit per byte lane.

   // ********************************************************************
   // Bus payload types.
   // ********************************************************************

   // Data word on the read and write paths.
   typedef logic [BUS_W-1:0] bus_word_t;

   // Byte address as issued by the CPU.
   typedef logic [BUS_W-1:0] bus_addr_t;

   // Byte-lane write mask.
   typedef logic [SEL_W-1:0] bus_sel_t;

endpackage

// File: verilog/soc_map_pkg.sv
package soc_map_pkg;

   import soc_bus_pkg::*;

   // ********************************************************************
   // Address map.
   // ********************************************************************

   localparam int REGION_W   = 2;
   localparam int REGION_MSB = BUS_W - 1;
   localparam int REGION_LSB = REGION_MSB - REGION_W + 1; // Bits 31..30.

   typedef enum logic [REGION_W-1:0] {
      REG_MEM   = 2'd0,
      REG_GPIO  = 2'd1,
      REG_TIMER = 2'd2,
      REG_NONE  = 2'd3 // Unmapped, reads as zero.
   } region_t;

   // Top address bits select the slave.
   function automatic region_t decode_region(input bus_addr_t adr);
      return region_t'(adr[REGION_MSB:REGION_LSB]);
   endfunction

   // Timer register select, taken from one address bit.
   localparam int TIMER_CMP_OFS = 2;

   typedef enum logic {TMR_MTIME = 1'b0, TMR_MTIMECMP = 1'b1} timer_reg_t;

endpackage

// File: verilog/soc_arbiter.sv
`timescale 1ns/1ps

module soc_arbiter import soc_bus_pkg::*; (
   input  logic      wb_clk,

   // Instruction bus, read only.
   input  bus_addr_t i_ibus_adr,
   input  logic      i_ibus_cyc,
   output bus_word_t o_ibus_rdt,
   output logic      o_ibus_ack,

   // Data bus.
   input  bus_addr_t i_dbus_adr,
   input  bus_word_t i_dbus_dat,
   input  bus_sel_t  i_dbus_sel,
   input  logic      i_dbus_we,
   input  logic      i_dbus_cyc,
   output bus_word_t o_dbus_rdt,
   output logic      o_dbus_ack,

   // Merged master bus.
   output bus_addr_t o_cpu_adr,
   output bus_word_t o_cpu_dat,
   output bus_sel_t  o_cpu_sel,
   output logic      o_cpu_we,
   output logic      o_cpu_cyc,
   input  bus_word_t i_cpu_rdt,
   input  logic      i_cpu_ack
);

   logic ibus_owner;

   assign ibus_owner = i_ibus_cyc; // Instruction fetch always wins.

   // ********************************************************************
   // Request path.
   // ********************************************************************

   assign o_cpu_adr = ibus_owner ? i_ibus_adr : i_dbus_adr;
   assign o_cpu_dat = i_dbus_dat;
   assign o_cpu_sel = ibus_owner ? '1 : i_dbus_sel; // Fetches read the full word.
   assign o_cpu_we  = i_dbus_we & ~ibus_owner;
   assign o_cpu_cyc = i_ibus_cyc | i_dbus_cyc;

   // ********************************************************************
   // Response path.
   // ********************************************************************

   assign o_ibus_rdt = i_cpu_rdt;
   assign o_dbus_rdt = i_cpu_rdt;
   assign o_ibus_ack = i_cpu_ack & ibus_owner;
   assign o_dbus_ack = i_cpu_ack & ~ibus_owner;

   a_dbus_ack_owner : assert property (@(posedge wb_clk) o_dbus_ack |-> i_dbus_cyc)
      else $error("Data bus ack without a data request.");

endmodule

// File: verilog/soc_addr_mux.sv
`timescale 1ns/1ps

module soc_addr_mux import soc_bus_pkg::*, soc_map_pkg::*; #(
   parameter int MEM_WORDS = 2048
) (
   input  logic                         wb_clk,
   input  logic                         i_rst,

   // Merged master bus.
   input  bus_addr_t                    i_cpu_adr,
   input  bus_word_t                    i_cpu_dat,
   input  bus_sel_t                     i_cpu_sel,
   input  logic                         i_cpu_we,
   input  logic                         i_cpu_cyc,
   output bus_word_t                    o_cpu_rdt,
   output logic                         o_cpu_ack,

   // RAM slave.
   output logic [$clog2(MEM_WORDS)-1:0] o_mem_adr,
   output bus_word_t                    o_mem_dat,
   output bus_sel_t                     o_mem_sel,
   output logic                         o_mem_we,
   output logic                         o_mem_cyc,
   input  bus_word_t                    i_mem_rdt,

   // GPIO slave.
   output logic                         o_gpio_dat,
   output logic                         o_gpio_cyc,
   output logic                         o_gpio_we,
   input  bus_word_t                    i_gpio_rdt,

   // Timer slave.
   output logic                         o_timer_adr,
   output bus_word_t                    o_timer_dat,
   output logic                         o_timer_we,
   output logic                         o_timer_cyc,
   input  bus_word_t                    i_timer_rdt
);

   localparam int MEM_AW = $clog2(MEM_WORDS);

   region_t region;
   logic    ack_r;

   assign region = decode_region(i_cpu_adr);

   // Single-cycle ack pulse, one cycle after cyc is seen.
   always_ff @(posedge wb_clk) begin
      if (i_rst)
         ack_r <= 1'b0;
      else
         ack_r <= i_cpu_cyc & ~ack_r;
   end

   assign o_cpu_ack = ack_r;

   // ********************************************************************
   // Slave selects.
   // ********************************************************************

   // RAM samples in the first cycle, registers in the ack cycle.
   assign o_mem_cyc   = i_cpu_cyc & ~ack_r & (region == REG_MEM);
   assign o_gpio_cyc  = i_cpu_cyc & ack_r & (region == REG_GPIO);
   assign o_timer_cyc = i_cpu_cyc & ack_r & (region == REG_TIMER);

   assign o_mem_adr   = i_cpu_adr[2 +: MEM_AW]; // Word index.
   assign o_mem_dat   = i_cpu_dat;
   assign o_mem_sel   = i_cpu_sel;
   assign o_mem_we    = i_cpu_we;
   assign o_gpio_dat  = i_cpu_dat[0];
   assign o_gpio_we   = i_cpu_we;
   assign o_timer_adr = i_cpu_adr[TIMER_CMP_OFS];
   assign o_timer_dat = i_cpu_dat;
   assign o_timer_we  = i_cpu_we;

   always_comb begin
      case (region)
         REG_MEM:   o_cpu_rdt = i_mem_rdt;
         REG_GPIO:  o_cpu_rdt = i_gpio_rdt;
         REG_TIMER: o_cpu_rdt = i_timer_rdt;
         default:   o_cpu_rdt = '0;
      endcase
   end

   a_req_stable : assert property (@(posedge wb_clk) disable iff (i_rst)
      (i_cpu_cyc && !ack_r) |=> (i_cpu_cyc && $stable(i_cpu_adr)))
      else $error("Request dropped or changed before ack.");

   a_mem_range : assert property (@(posedge wb_clk) disable iff (i_rst)
      o_mem_cyc |-> (i_cpu_adr[REGION_LSB-1:2] < MEM_WORDS))
      else $error("RAM access beyond %0d words.", MEM_WORDS);

endmodule

// File: verilog/soc_ram.sv
`timescale 1ns/1ps

module soc_ram import soc_bus_pkg::*; #(
   parameter int MEM_WORDS = 2048
) (
   input  logic                         wb_clk,
   input  logic [$clog2(MEM_WORDS)-1:0] i_adr,
   input  bus_word_t                    i_dat,
   input  bus_sel_t                     i_sel,
   input  logic                         i_we,
   input  logic                         i_cyc,
   output bus_word_t                    o_rdt
);

   bus_word_t mem [MEM_WORDS];

   // ********************************************************************
   // Write port with byte enables.
   // ********************************************************************

   always_ff @(posedge wb_clk) begin
      if (i_cyc && i_we) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (i_sel[b])
               mem[i_adr][8*b +: 8] <= i_dat[8*b +: 8];
         end
      end
   end

   // ********************************************************************
   // Read port.
   // ********************************************************************

   // Old word is returned on a write cycle.
   always_ff @(posedge wb_clk) begin
      if (i_cyc)
         o_rdt <= mem[i_adr];
   end

   a_write_sel : assert property (@(posedge wb_clk) (i_cyc && i_we) |-> (i_sel != '0))
      else $error("RAM write with empty byte select.");

endmodule

// File: verilog/soc_timer.sv
`timescale 1ns/1ps

module soc_timer import soc_bus_pkg::*, soc_map_pkg::*; (
   input  logic      wb_clk,
   input  logic      i_rst,
   input  logic      i_adr,
   input  bus_word_t i_dat,
   input  logic      i_we,
   input  logic      i_cyc,
   output bus_word_t o_rdt,
   output logic      o_irq
);

   bus_word_t  mtime;
   bus_word_t  mtimecmp;
   timer_reg_t reg_sel;

   assign reg_sel = timer_reg_t'(i_adr);

   // ********************************************************************
   // Counter and compare register.
   // ********************************************************************

   always_ff @(posedge wb_clk) begin
      if (i_rst) begin
         mtime    <= '0;
         mtimecmp <= '1; // Far in the future, no interrupt.
      end else begin
         mtime <= mtime + 1'b1;
         if (i_cyc && i_we && reg_sel == TMR_MTIMECMP)
            mtimecmp <= i_dat;
      end
   end

   // Level interrupt, cleared only by moving mtimecmp past mtime.
   always_ff @(posedge wb_clk) begin
      if (i_rst)
         o_irq <= 1'b0;
      else
         o_irq <= (mtime >= mtimecmp);
   end

   // ********************************************************************
   // Readback.
   // ********************************************************************

   always_comb begin
      case (reg_sel)
         TMR_MTIMECMP: o_rdt = mtimecmp;
         default:      o_rdt = mtime;
      endcase
   end

endmodule

// File: verilog/soc_gpio.sv
`timescale 1ns/1ps

module soc_gpio import soc_bus_pkg::*; (
   input  logic      wb_clk,
   input  logic      i_rst,
   input  logic      i_dat,
   input  logic      i_we,
   input  logic      i_cyc,
   output bus_word_t o_rdt,
   output logic      o_gpio
);

   logic gpio_q;

   // Output latch, written in the ack cycle.
   always_ff @(posedge wb_clk) begin
      if (i_rst)
         gpio_q <= 1'b0;
      else if (i_cyc && i_we)
         gpio_q <= i_dat;
   end

   assign o_gpio = gpio_q;
   assign o_rdt  = {{(BUS_W-1){1'b0}}, gpio_q}; // Zero-extended.

endmodule

// File: verilog/soc_subsystem.sv
`timescale 1ns/1ps

module soc_subsystem import soc_bus_pkg::*; #(
   parameter int MEM_WORDS = 2048
) (
   input  logic      wb_clk,
   input  logic      i_rst,

   input  bus_addr_t i_ibus_adr,
   input  logic      i_ibus_cyc,
   output bus_word_t o_ibus_rdt,
   output logic      o_ibus_ack,

   input  bus_addr_t i_dbus_adr,
   input  bus_word_t i_dbus_dat,
   input  bus_sel_t  i_dbus_sel,
   input  logic      i_dbus_we,
   input  logic      i_dbus_cyc,
   output bus_word_t o_dbus_rdt,
   output logic      o_dbus_ack,

   output logic      o_gpio,
   output logic      o_timer_irq
);

   // ********************************************************************
   // Merged bus and slave buses.
   // ********************************************************************

   bus_addr_t wb_cpu_adr;
   bus_word_t wb_cpu_dat;
   bus_sel_t  wb_cpu_sel;
   logic      wb_cpu_we;
   logic      wb_cpu_cyc;
   bus_word_t wb_cpu_rdt;
   logic      wb_cpu_ack;

   logic [$clog2(MEM_WORDS)-1:0] wb_mem_adr;
   bus_word_t wb_mem_dat;
   bus_sel_t  wb_mem_sel;
   logic      wb_mem_we;
   logic      wb_mem_cyc;
   bus_word_t wb_mem_rdt;

   logic      wb_gpio_dat;
   logic      wb_gpio_cyc;
   logic      wb_gpio_we;
   bus_word_t wb_gpio_rdt;

   logic      wb_timer_adr;
   bus_word_t wb_timer_dat;
   logic      wb_timer_we;
   logic      wb_timer_cyc;
   bus_word_t wb_timer_rdt;

   soc_arbiter soc_arbiter_i (
      .wb_clk     (wb_clk),
      .i_ibus_adr (i_ibus_adr), .i_ibus_cyc (i_ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt), .o_ibus_ack (o_ibus_ack),
      .i_dbus_adr (i_dbus_adr), .i_dbus_dat (i_dbus_dat), .i_dbus_sel (i_dbus_sel),
      .i_dbus_we  (i_dbus_we),  .i_dbus_cyc (i_dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt), .o_dbus_ack (o_dbus_ack),
      .o_cpu_adr  (wb_cpu_adr), .o_cpu_dat  (wb_cpu_dat), .o_cpu_sel (wb_cpu_sel),
      .o_cpu_we   (wb_cpu_we),  .o_cpu_cyc  (wb_cpu_cyc),
      .i_cpu_rdt  (wb_cpu_rdt), .i_cpu_ack  (wb_cpu_ack));

   soc_addr_mux #(.MEM_WORDS (MEM_WORDS)) soc_addr_mux_i (
      .wb_clk      (wb_clk),       .i_rst       (i_rst),
      .i_cpu_adr   (wb_cpu_adr),   .i_cpu_dat   (wb_cpu_dat),  .i_cpu_sel (wb_cpu_sel),
      .i_cpu_we    (wb_cpu_we),    .i_cpu_cyc   (wb_cpu_cyc),
      .o_cpu_rdt   (wb_cpu_rdt),   .o_cpu_ack   (wb_cpu_ack),
      .o_mem_adr   (wb_mem_adr),   .o_mem_dat   (wb_mem_dat),  .o_mem_sel (wb_mem_sel),
      .o_mem_we    (wb_mem_we),    .o_mem_cyc   (wb_mem_cyc),  .i_mem_rdt (wb_mem_rdt),
      .o_gpio_dat  (wb_gpio_dat),  .o_gpio_cyc  (wb_gpio_cyc),
      .o_gpio_we   (wb_gpio_we),   .i_gpio_rdt  (wb_gpio_rdt),
      .o_timer_adr (wb_timer_adr), .o_timer_dat (wb_timer_dat),
      .o_timer_we  (wb_timer_we),  .o_timer_cyc (wb_timer_cyc),
      .i_timer_rdt (wb_timer_rdt));

   soc_ram #(.MEM_WORDS (MEM_WORDS)) soc_ram_i (
      .wb_clk (wb_clk),     .i_adr (wb_mem_adr), .i_dat (wb_mem_dat),
      .i_sel  (wb_mem_sel), .i_we  (wb_mem_we),  .i_cyc (wb_mem_cyc),
      .o_rdt  (wb_mem_rdt));

   soc_timer soc_timer_i (
      .wb_clk (wb_clk),       .i_rst (i_rst),       .i_adr (wb_timer_adr),
      .i_dat  (wb_timer_dat), .i_we  (wb_timer_we), .i_cyc (wb_timer_cyc),
      .o_rdt  (wb_timer_rdt), .o_irq (o_timer_irq));

   soc_gpio soc_gpio_i (
      .wb_clk (wb_clk),      .i_rst (i_rst),      .i_dat  (wb_gpio_dat),
      .i_we   (wb_gpio_we),  .i_cyc (wb_gpio_cyc),
      .o_rdt  (wb_gpio_rdt), .o_gpio (o_gpio));

endmodule

// File: verification/soc_tb_tasks.svh
`ifndef SOC_TB_TASKS_SVH
`define SOC_TB_TASKS_SVH

// ********************************************************************
// Typed compare tasks.
// ********************************************************************

task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
   if (got !== exp)
      stop_with_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp)
      stop_with_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

// ********************************************************************
// Bus access tasks. All start and end just after a rising edge.
// ********************************************************************

task automatic wait_for_ack(input port_t port);
   int waited;
   waited = 0;
   @(posedge wb_clk);
   #DRIVE_DLY;
   while (!(port == PORT_IBUS ? o_ibus_ack : o_dbus_ack)) begin
      if (waited == ACK_TIMEOUT)
         stop_with_error(port == PORT_IBUS ? "Timeout waiting for o_ibus_ack."
                                           : "Timeout waiting for o_dbus_ack.");
      waited++;
      @(posedge wb_clk);
      #DRIVE_DLY;
   end
endtask

task automatic fetch_word(input bus_addr_t adr, output bus_word_t rdt);
   ibus_adr = adr;
   ibus_cyc = 1'b1;
   wait_for_ack(PORT_IBUS);
   rdt = o_ibus_rdt;
   @(posedge wb_clk); // Hold cyc through the ack cycle.
   #DRIVE_DLY;
   ibus_cyc = 1'b0;
   ibus_adr = '0;
endtask

task automatic data_access(input logic we, input bus_addr_t adr, input bus_word_t dat,
                           input bus_sel_t sel, output bus_word_t rdt);
   dbus_adr = adr;
   dbus_dat = dat;
   dbus_sel = sel;
   dbus_we  = we;
   dbus_cyc = 1'b1;
   wait_for_ack(PORT_DBUS);
   rdt = o_dbus_rdt;
   @(posedge wb_clk); // Timer and GPIO write on this edge.
   #DRIVE_DLY;
   dbus_cyc = 1'b0;
   dbus_we  = 1'b0;
   dbus_sel = '0;
   dbus_dat = '0;
   dbus_adr = '0;
endtask

`endif

// File: verification/soc_tb.sv
`timescale 1ns/1ps

module soc_tb import soc_bus_pkg::*, soc_map_pkg::*;;

   localparam int        MEM_WORDS   = 2048;
   localparam int        SEED        = 62;
   localparam int        DRIVE_DLY   = 1;
   localparam int        ACK_TIMEOUT = 20;  // Cycles.
   localparam int        IRQ_TIMEOUT = 100; // Cycles.
   localparam bus_addr_t RAM_A       = 32'h0000_0100;
   localparam bus_addr_t RAM_B       = 32'h0000_0104;
   localparam bus_addr_t GPIO_BASE   = 32'h4000_0000;
   localparam bus_addr_t TIMER_BASE  = 32'h8000_0000;
   localparam bus_addr_t TIMER_CMP   = TIMER_BASE | (32'h1 << TIMER_CMP_OFS);
   localparam bus_addr_t NONE_BASE   = 32'hC000_0010;

   typedef enum logic {PORT_IBUS, PORT_DBUS} port_t;

   typedef struct {
      port_t     port;
      logic      we;
      bus_addr_t adr;
      bus_word_t dat;
      bus_sel_t  sel;
      bus_word_t exp;
   } step_t;

   logic      wb_clk;
   logic      i_rst;
   bus_addr_t ibus_adr;
   logic      ibus_cyc;
   bus_word_t o_ibus_rdt;
   logic      o_ibus_ack;
   bus_addr_t dbus_adr;
   bus_word_t dbus_dat;
   bus_sel_t  dbus_sel;
   logic      dbus_we;
   logic      dbus_cyc;
   bus_word_t o_dbus_rdt;
   logic      o_dbus_ack;
   logic      o_gpio;
   logic      o_timer_irq;

   step_t     steps[$];
   bus_word_t ram_model [bus_addr_t]; // Keyed by word-aligned address.
   logic      gpio_model;

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   soc_subsystem #(.MEM_WORDS (MEM_WORDS)) soc_subsystem_i (
      .wb_clk     (wb_clk),     .i_rst      (i_rst),
      .i_ibus_adr (ibus_adr),   .i_ibus_cyc (ibus_cyc),
      .o_ibus_rdt (o_ibus_rdt), .o_ibus_ack (o_ibus_ack),
      .i_dbus_adr (dbus_adr),   .i_dbus_dat (dbus_dat),   .i_dbus_sel (dbus_sel),
      .i_dbus_we  (dbus_we),    .i_dbus_cyc (dbus_cyc),
      .o_dbus_rdt (o_dbus_rdt), .o_dbus_ack (o_dbus_ack),
      .o_gpio     (o_gpio),     .o_timer_irq (o_timer_irq));

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   `include "soc_tb_tasks.svh"

   // ********************************************************************
   // Reference model of the address map.
   // ********************************************************************

   function automatic bus_word_t merge_lanes(input bus_word_t old_w, input bus_word_t new_w,
                                             input bus_sel_t sel);
      bus_word_t res;
      res = old_w;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   function automatic bus_word_t expected_read(input bus_addr_t adr);
      case (region_t'(adr[31:30]))
         REG_MEM:  return ram_model[{adr[31:2], 2'b00}];
         REG_GPIO: return {{(BUS_W-1){1'b0}}, gpio_model};
         default:  return '0; // Unmapped reads zero.
      endcase
   endfunction

   task automatic add_step(input port_t port, input logic we, input bus_addr_t adr,
                           input bus_word_t dat, input bus_sel_t sel);
      step_t     s;
      bus_addr_t key;
      key = {adr[31:2], 2'b00};
      if (we && region_t'(adr[31:30]) == REG_MEM)
         ram_model[key] = merge_lanes(ram_model.exists(key) ? ram_model[key] : '0, dat, sel);
      if (we && region_t'(adr[31:30]) == REG_GPIO)
         gpio_model = dat[0];
      s.port = port;
      s.we   = we;
      s.adr  = adr;
      s.dat  = dat;
      s.sel  = sel;
      s.exp  = expected_read(adr);
      steps.push_back(s);
   endtask

   // ********************************************************************
   // Main sequence.
   // ********************************************************************

   initial begin
      bus_word_t rdt;
      bus_word_t rdt2;
      bus_word_t t1;
      bus_word_t t2;
      int        waited;

      i_rst    = 1'b1;
      ibus_adr = '0;
      ibus_cyc = 1'b0;
      dbus_adr = '0;
      dbus_dat = '0;
      dbus_sel = '0;
      dbus_we  = 1'b0;
      dbus_cyc = 1'b0;
      gpio_model = 1'b0;
      void'($urandom(SEED));

      add_step(PORT_DBUS, 1'b1, RAM_A, $urandom(), 4'hF);
      add_step(PORT_DBUS, 1'b1, RAM_B, $urandom(), 4'hF);
      add_step(PORT_DBUS, 1'b1, RAM_A, $urandom(), 4'h1); // Single lanes.
      add_step(PORT_DBUS, 1'b1, RAM_A, $urandom(), 4'h4);
      add_step(PORT_DBUS, 1'b0, RAM_A, '0, 4'hF);
      add_step(PORT_DBUS, 1'b1, RAM_A, $urandom(), 4'h2);
      add_step(PORT_DBUS, 1'b1, RAM_A, $urandom(), 4'h8);
      add_step(PORT_DBUS, 1'b0, RAM_A, '0, 4'hF);
      add_step(PORT_IBUS, 1'b0, RAM_A, '0, 4'hF); // Fetch sees data-bus writes.
      add_step(PORT_DBUS, 1'b1, GPIO_BASE, $urandom() | 32'h1, 4'hF);
      add_step(PORT_DBUS, 1'b0, GPIO_BASE, '0, 4'hF);
      add_step(PORT_DBUS, 1'b1, GPIO_BASE, $urandom() & ~32'h1, 4'hF);
      add_step(PORT_DBUS, 1'b0, GPIO_BASE, '0, 4'hF);
      add_step(PORT_DBUS, 1'b0, NONE_BASE, '0, 4'hF);
      add_step(PORT_IBUS, 1'b0, NONE_BASE + 32'h10, '0, 4'hF);

      repeat (4) @(posedge wb_clk);
      #DRIVE_DLY;
      i_rst = 1'b0;

      check_bit("o_gpio", o_gpio, 1'b0);
      check_bit("o_timer_irq", o_timer_irq, 1'b0);
      check_bit("o_ibus_ack", o_ibus_ack, 1'b0);
      check_bit("o_dbus_ack", o_dbus_ack, 1'b0);

      foreach (steps[n]) begin
         if (steps[n].port == PORT_IBUS)
            fetch_word(steps[n].adr, rdt);
         else
            data_access(steps[n].we, steps[n].adr, steps[n].dat, steps[n].sel, rdt);
         if (!steps[n].we)
            check_word($sformatf("%s (step %0d)", steps[n].port == PORT_IBUS ?
                       "o_ibus_rdt" : "o_dbus_rdt", n), rdt, steps[n].exp);
         if (steps[n].we && region_t'(steps[n].adr[31:30]) == REG_GPIO)
            check_bit("o_gpio", o_gpio, steps[n].dat[0]);
      end

      // Both masters request together. Fetch goes first.
      ibus_adr = RAM_B;
      ibus_cyc = 1'b1;
      dbus_adr = RAM_A;
      dbus_sel = 4'hF;
      dbus_cyc = 1'b1;
      wait_for_ack(PORT_IBUS);
      check_bit("o_dbus_ack", o_dbus_ack, 1'b0);
      check_word("o_ibus_rdt", o_ibus_rdt, expected_read(RAM_B));
      @(posedge wb_clk);
      #DRIVE_DLY;
      ibus_cyc = 1'b0;
      wait_for_ack(PORT_DBUS);
      check_word("o_dbus_rdt", o_dbus_rdt, expected_read(RAM_A));
      @(posedge wb_clk);
      #DRIVE_DLY;
      dbus_cyc = 1'b0;
      dbus_sel = '0;

      // ********************************************************************
      // Machine timer.
      // ********************************************************************

      data_access(1'b0, TIMER_BASE, '0, 4'hF, t1);
      data_access(1'b0, TIMER_BASE, '0, 4'hF, t2);
      if (!(t2 > t1))
         stop_with_error($sformatf("mtime did not advance: 0x%h then 0x%h.", t1, t2));
      data_access(1'b1, TIMER_CMP, t2 + 32'd40, 4'hF, rdt);
      check_bit("o_timer_irq", o_timer_irq, 1'b0);
      data_access(1'b0, TIMER_CMP, '0, 4'hF, rdt2);
      check_word("mtimecmp", rdt2, t2 + 32'd40);

      waited = 0;
      while (!o_timer_irq) begin
         if (waited == IRQ_TIMEOUT)
            stop_with_error("Timeout waiting for o_timer_irq to rise.");
         waited++;
         @(posedge wb_clk);
         #DRIVE_DLY;
      end

      data_access(1'b1, TIMER_CMP, '1, 4'hF, rdt);
      @(posedge wb_clk); // Interrupt is registered one cycle later.
      #DRIVE_DLY;
      check_bit("o_timer_irq", o_timer_irq, 1'b0);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: build.f
+incdir+verification
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/soc_arbiter.sv
verilog/soc_addr_mux.sv
verilog/soc_ram.sv
verilog/soc_timer.sv
verilog/soc_gpio.sv
verilog/soc_subsystem.sv
verification/soc_tb.sv
